// ==== src/mmu_pkg.sv ====
package mmu_pkg;

    parameter int page_offset_bits = 12;

    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    // top bit selects the source, low bits are the sequence count
    typedef logic [2:0]  walk_tag_t;

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } vpn_t;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
    } ppn_t;

    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    typedef struct packed {
        logic      valid;
        walk_tag_t tag;
        vaddr_t    vaddr;
    } walk_req_t;

    typedef struct packed {
        logic      valid;
        walk_tag_t tag;
        logic      exception;
        pte_t      pte;
        logic      superpage;
        vaddr_t    vaddr;
    } walk_resp_t;

    typedef struct packed {
        logic valid;
        vpn_t vpn;
        logic superpage;
        ppn_t ppn;
        logic r;
        logic w;
        logic x;
        logic u;
    } tlb_entry_t;

    typedef enum logic [1:0] {IDLE, WALK0, WALK1} miss_state_t;
    typedef enum logic [1:0] {WALK_IDLE, READ1, READ0, DONE} walk_state_t;

    // a superpage passes vpn0 through in place of ppn0
    function automatic paddr_t make_paddr(tlb_entry_t e, vaddr_t va);
        vpn_t vpn;
        vpn = va[31:page_offset_bits];
        return {e.ppn.ppn1, e.superpage ? vpn.vpn0 : e.ppn.ppn0, va[page_offset_bits-1:0]};
    endfunction

    function automatic tlb_entry_t entry_from_resp(walk_resp_t rsp);
        tlb_entry_t e;
        e.valid     = 1'b1;
        e.vpn       = rsp.vaddr[31:page_offset_bits];
        e.superpage = rsp.superpage;
        e.ppn       = rsp.pte.ppn;
        e.r         = rsp.pte.r;
        e.w         = rsp.pte.w;
        e.x         = rsp.pte.x;
        e.u         = rsp.pte.u;
        return e;
    endfunction

    // user mode only, so u is always required
    function automatic logic perm_fault(tlb_entry_t e, logic fetch, logic store);
        logic need;
        need = fetch ? e.x : (store ? e.w : e.r);
        return ~e.u | ~need;
    endfunction

endpackage

// ==== src/tlb_array.sv ====
`timescale 1ns/1ps

module tlb_array #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  mmu_pkg::vpn_t       lookup_vpn,
    input  logic                we,
    input  mmu_pkg::tlb_entry_t wentry,
    output logic                hit,
    output mmu_pkg::tlb_entry_t hit_entry
);
    localparam int IDX_W = $clog2(TLB_ENTRIES);

    mmu_pkg::tlb_entry_t    entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid;
    logic [7:0]             lfsr;
    logic [IDX_W-1:0]       victim;
    logic                   free_found;

    // superpage entries compare vpn1 only
    always_comb begin
        hit = 1'b0;
        hit_entry = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && valid[i] && entries[i].vpn.vpn1 == lookup_vpn.vpn1 &&
                (entries[i].superpage || entries[i].vpn.vpn0 == lookup_vpn.vpn0)) begin
                hit = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

    // first free slot wins over the random pick
    always_comb begin
        victim = lfsr[IDX_W-1:0];
        free_found = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!free_found && !valid[i]) begin
                free_found = 1'b1;
                victim = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            lfsr <= 8'h01;
        end else begin
            // galois step, x^8 + x^6 + x^5 + x^4 + 1
            lfsr <= {1'b0, lfsr[7:1]} ^ (lfsr[0] ? 8'hb8 : 8'h00);
            if (flush) begin
                valid <= '0;
            end else if (we && wentry.valid) begin
                valid[victim] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we && !flush) begin
            entries[victim] <= wentry;
        end
    end

endmodule

// ==== src/itlb.sv ====
`timescale 1ns/1ps

module itlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic [1:0]            req,
    input  mmu_pkg::vaddr_t [1:0] vaddr,
    input  logic                  ready,
    input  mmu_pkg::walk_resp_t   resp,
    output mmu_pkg::paddr_t [1:0] paddr,
    output logic                  miss,
    output logic [1:0]            exception,
    output mmu_pkg::walk_req_t    walk_req
);
    mmu_pkg::miss_state_t  state;
    mmu_pkg::tlb_entry_t   hit_entry [2];
    mmu_pkg::tlb_entry_t   refill_entry;
    mmu_pkg::paddr_t [1:0] look_paddr;
    mmu_pkg::paddr_t [1:0] buf_paddr;
    mmu_pkg::vaddr_t [1:0] buf_vaddr;
    mmu_pkg::vaddr_t       walk_vaddr;
    logic [1:0]            hit;
    logic [1:0]            port_miss;
    logic [1:0]            port_exc;
    logic [1:0]            buf_miss;
    logic [1:0]            buf_exc;
    logic [1:0]            seq;
    logic                  walk_valid;
    logic                  miss_end;
    logic                  resp_ok;
    logic                  refill_we;
    logic                  resp_fault;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup, one entry store per port, both refilled together
    for (genvar i = 0; i < 2; i++) begin : g_port
        tlb_array #(.TLB_ENTRIES(TLB_ENTRIES)) u_array (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .lookup_vpn(vaddr[i][31:mmu_pkg::page_offset_bits]),
            .we        (refill_we),
            .wentry    (refill_entry),
            .hit       (hit[i]),
            .hit_entry (hit_entry[i])
        );
        assign look_paddr[i] = mmu_pkg::make_paddr(hit_entry[i], vaddr[i]);
        assign port_exc[i] = req[i] & hit[i] & mmu_pkg::perm_fault(hit_entry[i], 1'b1, 1'b0);
        assign port_miss[i] = req[i] & ~flush & ~hit[i];
        assign paddr[i] = miss_end ? buf_paddr[i] : look_paddr[i];
        assign exception[i] = (state == mmu_pkg::IDLE) & (miss_end ? buf_exc[i] : port_exc[i]);
    end

    assign miss = (state != mmu_pkg::IDLE) | (~miss_end & (|port_miss));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // refill, a faulting walk is reported but never cached
    assign resp_ok = resp.valid & (resp.tag[1:0] == seq) & (state != mmu_pkg::IDLE) & ~flush;
    assign refill_we = resp_ok & ~resp.exception;
    assign refill_entry = mmu_pkg::entry_from_resp(resp);
    assign resp_fault = resp.exception | mmu_pkg::perm_fault(refill_entry, 1'b1, 1'b0);

    assign walk_req.valid = walk_valid;
    assign walk_req.tag = {1'b0, seq};
    assign walk_req.vaddr = walk_vaddr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mmu_pkg::IDLE;
            miss_end <= 1'b0;
            walk_valid <= 1'b0;
            seq <= '0;
            buf_miss <= '0;
            buf_exc <= '0;
            buf_paddr <= '0;
            buf_vaddr <= '0;
            walk_vaddr <= '0;
        end else if (flush) begin
            // bump the count so a walk still in flight is dropped
            state <= mmu_pkg::IDLE;
            miss_end <= 1'b0;
            walk_valid <= 1'b0;
            seq <= seq + 2'd1;
        end else begin
            walk_valid <= 1'b0;
            if (miss_end && ready) begin
                miss_end <= 1'b0;
            end
            case (state)
                mmu_pkg::IDLE: begin
                    if (|port_miss && !miss_end) begin
                        buf_miss <= port_miss;
                        buf_vaddr <= vaddr;
                        buf_paddr <= look_paddr;
                        buf_exc <= port_exc;
                        walk_valid <= 1'b1;
                        seq <= seq + 2'd1;
                        state <= port_miss[0] ? mmu_pkg::WALK0 : mmu_pkg::WALK1;
                        walk_vaddr <= port_miss[0] ? vaddr[0] : vaddr[1];
                    end
                end
                mmu_pkg::WALK0: begin
                    if (resp_ok) begin
                        buf_paddr[0] <= mmu_pkg::make_paddr(refill_entry, resp.vaddr);
                        buf_exc[0] <= resp_fault;
                        if (buf_miss[1]) begin
                            state <= mmu_pkg::WALK1;
                            walk_valid <= 1'b1;
                            seq <= seq + 2'd1;
                            walk_vaddr <= buf_vaddr[1];
                        end else begin
                            state <= mmu_pkg::IDLE;
                            miss_end <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (resp_ok) begin
                        buf_paddr[1] <= mmu_pkg::make_paddr(refill_entry, resp.vaddr);
                        buf_exc[1] <= resp_fault;
                        state <= mmu_pkg::IDLE;
                        miss_end <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== src/dtlb.sv ====
`timescale 1ns/1ps

module dtlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                req,
    input  logic                store,
    input  mmu_pkg::vaddr_t     vaddr,
    input  logic                ready,
    input  mmu_pkg::walk_resp_t resp,
    output mmu_pkg::paddr_t     paddr,
    output logic                miss,
    output logic                exception,
    output mmu_pkg::walk_req_t  walk_req
);
    mmu_pkg::miss_state_t state;
    mmu_pkg::tlb_entry_t  hit_entry;
    mmu_pkg::tlb_entry_t  refill_entry;
    mmu_pkg::paddr_t      buf_paddr;
    mmu_pkg::vaddr_t      walk_vaddr;
    logic                 hit;
    logic                 port_miss;
    logic                 port_exc;
    logic                 buf_exc;
    logic                 buf_store;
    logic [1:0]           seq;
    logic                 walk_valid;
    logic                 miss_end;
    logic                 resp_ok;

    tlb_array #(.TLB_ENTRIES(TLB_ENTRIES)) u_array (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .lookup_vpn(vaddr[31:mmu_pkg::page_offset_bits]),
        .we        (resp_ok & ~resp.exception),
        .wentry    (refill_entry),
        .hit       (hit),
        .hit_entry (hit_entry)
    );

    assign port_exc = req & hit & mmu_pkg::perm_fault(hit_entry, 1'b0, store);
    assign port_miss = req & ~flush & ~hit;
    assign paddr = miss_end ? buf_paddr : mmu_pkg::make_paddr(hit_entry, vaddr);
    assign exception = (state == mmu_pkg::IDLE) & (miss_end ? buf_exc : port_exc);
    assign miss = (state != mmu_pkg::IDLE) | (~miss_end & port_miss);

    assign resp_ok = resp.valid & (resp.tag[1:0] == seq) & (state != mmu_pkg::IDLE) & ~flush;
    assign refill_entry = mmu_pkg::entry_from_resp(resp);

    assign walk_req.valid = walk_valid;
    assign walk_req.tag = {1'b1, seq};
    assign walk_req.vaddr = walk_vaddr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mmu_pkg::IDLE;
            miss_end <= 1'b0;
            walk_valid <= 1'b0;
            seq <= '0;
            buf_exc <= 1'b0;
            buf_store <= 1'b0;
            buf_paddr <= '0;
            walk_vaddr <= '0;
        end else if (flush) begin
            state <= mmu_pkg::IDLE;
            miss_end <= 1'b0;
            walk_valid <= 1'b0;
            seq <= seq + 2'd1;
        end else begin
            walk_valid <= 1'b0;
            if (miss_end && ready) begin
                miss_end <= 1'b0;
            end
            if (state == mmu_pkg::IDLE) begin
                if (port_miss && !miss_end) begin
                    buf_store <= store;
                    walk_vaddr <= vaddr;
                    walk_valid <= 1'b1;
                    seq <= seq + 2'd1;
                    state <= mmu_pkg::WALK0;
                end
            end else if (resp_ok) begin
                buf_paddr <= mmu_pkg::make_paddr(refill_entry, resp.vaddr);
                buf_exc <= resp.exception | mmu_pkg::perm_fault(refill_entry, 1'b0, buf_store);
                state <= mmu_pkg::IDLE;
                miss_end <= 1'b1;
            end
        end
    end

endmodule

// ==== src/walk_arbiter.sv ====
`timescale 1ns/1ps

module walk_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  mmu_pkg::walk_req_t  ireq_walk,
    input  mmu_pkg::walk_req_t  dreq_walk,
    input  logic                walker_ready,
    input  mmu_pkg::walk_resp_t walker_resp,
    output mmu_pkg::walk_req_t  walker_req,
    output mmu_pkg::walk_resp_t iresp,
    output mmu_pkg::walk_resp_t dresp
);
    mmu_pkg::walk_req_t islot;
    mmu_pkg::walk_req_t dslot;
    mmu_pkg::walk_req_t icur;
    mmu_pkg::walk_req_t dcur;
    logic               can_send;
    logic               grant_i;
    logic               grant_d;
    logic               prefer_d;

    // a fresh pulse goes straight through when its slot is empty
    assign icur = ireq_walk.valid ? ireq_walk : islot;
    assign dcur = dreq_walk.valid ? dreq_walk : dslot;

    // walker still shows ready in the cycle it takes a request
    assign can_send = walker_ready & ~walker_req.valid;
    assign grant_i = can_send & icur.valid & (~dcur.valid | ~prefer_d);
    assign grant_d = can_send & dcur.valid & ~grant_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            islot <= '0;
            dslot <= '0;
            walker_req <= '0;
            prefer_d <= 1'b0;
        end else if (flush) begin
            islot.valid <= 1'b0;
            dslot.valid <= 1'b0;
            walker_req.valid <= 1'b0;
        end else begin
            islot <= icur;
            islot.valid <= icur.valid & ~grant_i;
            dslot <= dcur;
            dslot.valid <= dcur.valid & ~grant_d;
            walker_req.valid <= 1'b0;
            if (grant_i) begin
                walker_req <= icur;
                prefer_d <= 1'b1;
            end else if (grant_d) begin
                walker_req <= dcur;
                prefer_d <= 1'b0;
            end
        end
    end

    always_comb begin
        iresp = walker_resp;
        dresp = walker_resp;
        iresp.valid = walker_resp.valid & ~walker_resp.tag[2];
        dresp.valid = walker_resp.valid & walker_resp.tag[2];
    end

endmodule

// ==== src/page_walker.sv ====
`timescale 1ns/1ps

module page_walker (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  mmu_pkg::ppn_t       satp_ppn,
    input  mmu_pkg::walk_req_t  req,
    input  logic                mem_rvalid,
    input  mmu_pkg::pte_t       mem_rdata,
    output logic                ready,
    output mmu_pkg::walk_resp_t resp,
    output logic                mem_req,
    output mmu_pkg::paddr_t     mem_addr
);
    mmu_pkg::walk_state_t state;
    mmu_pkg::walk_resp_t  resp_q;
    mmu_pkg::vpn_t        vpn;
    mmu_pkg::vpn_t        req_vpn;
    logic                 pte_leaf;
    logic                 pte_bad;

    assign vpn = resp_q.vaddr[31:mmu_pkg::page_offset_bits];
    assign req_vpn = req.vaddr[31:mmu_pkg::page_offset_bits];

    // w without r is a reserved encoding
    assign pte_leaf = mem_rdata.r | mem_rdata.x;
    assign pte_bad = ~mem_rdata.v | (mem_rdata.w & ~mem_rdata.r);

    assign ready = (state == mmu_pkg::WALK_IDLE);

    always_comb begin
        resp = resp_q;
        resp.valid = (state == mmu_pkg::DONE);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two-level walk, each read is a request plus one response cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mmu_pkg::WALK_IDLE;
            mem_req <= 1'b0;
            mem_addr <= '0;
            resp_q <= '0;
        end else begin
            mem_req <= 1'b0;
            if (flush) begin
                state <= mmu_pkg::WALK_IDLE;
            end else begin
                case (state)
                    mmu_pkg::WALK_IDLE: begin
                        if (req.valid) begin
                            resp_q.tag <= req.tag;
                            resp_q.vaddr <= req.vaddr;
                            resp_q.exception <= 1'b0;
                            resp_q.superpage <= 1'b0;
                            // root table base plus vpn1 * 4
                            mem_req <= 1'b1;
                            mem_addr <= {satp_ppn, req_vpn.vpn1, 2'b00};
                            state <= mmu_pkg::READ1;
                        end
                    end
                    mmu_pkg::READ1: begin
                        if (mem_rvalid) begin
                            resp_q.pte <= mem_rdata;
                            if (pte_bad) begin
                                resp_q.exception <= 1'b1;
                                state <= mmu_pkg::DONE;
                            end else if (pte_leaf) begin
                                resp_q.superpage <= 1'b1;
                                state <= mmu_pkg::DONE;
                            end else begin
                                mem_req <= 1'b1;
                                mem_addr <= {mem_rdata.ppn, vpn.vpn0, 2'b00};
                                state <= mmu_pkg::READ0;
                            end
                        end
                    end
                    mmu_pkg::READ0: begin
                        if (mem_rvalid) begin
                            resp_q.pte <= mem_rdata;
                            // no further level below 0
                            resp_q.exception <= pte_bad | ~pte_leaf;
                            state <= mmu_pkg::DONE;
                        end
                    end
                    default: begin
                        state <= mmu_pkg::WALK_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  mmu_pkg::ppn_t         satp_ppn,
    input  logic [1:0]            ireq,
    input  mmu_pkg::vaddr_t [1:0] ivaddr,
    input  logic                  iready,
    output mmu_pkg::paddr_t [1:0] ipaddr,
    output logic                  imiss,
    output logic [1:0]            iexception,
    input  logic                  dreq,
    input  logic                  dstore,
    input  mmu_pkg::vaddr_t       dvaddr,
    input  logic                  dready,
    output mmu_pkg::paddr_t       dpaddr,
    output logic                  dmiss,
    output logic                  dexception,
    output logic                  mem_req,
    output mmu_pkg::paddr_t       mem_addr,
    input  logic                  mem_rvalid,
    input  mmu_pkg::pte_t         mem_rdata
);
    mmu_pkg::walk_req_t  iwalk_req;
    mmu_pkg::walk_req_t  dwalk_req;
    mmu_pkg::walk_req_t  walker_req;
    mmu_pkg::walk_resp_t walker_resp;
    mmu_pkg::walk_resp_t iresp;
    mmu_pkg::walk_resp_t dresp;
    logic                walker_ready;

    itlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_itlb (
        .clk, .rst, .flush,
        .req      (ireq),
        .vaddr    (ivaddr),
        .ready    (iready),
        .resp     (iresp),
        .paddr    (ipaddr),
        .miss     (imiss),
        .exception(iexception),
        .walk_req (iwalk_req)
    );

    dtlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_dtlb (
        .clk, .rst, .flush,
        .req      (dreq),
        .store    (dstore),
        .vaddr    (dvaddr),
        .ready    (dready),
        .resp     (dresp),
        .paddr    (dpaddr),
        .miss     (dmiss),
        .exception(dexception),
        .walk_req (dwalk_req)
    );

    walk_arbiter u_arbiter (
        .clk, .rst, .flush,
        .ireq_walk   (iwalk_req),
        .dreq_walk   (dwalk_req),
        .walker_ready(walker_ready),
        .walker_resp (walker_resp),
        .walker_req  (walker_req),
        .iresp       (iresp),
        .dresp       (dresp)
    );

    page_walker u_walker (
        .clk, .rst, .flush,
        .satp_ppn  (satp_ppn),
        .req       (walker_req),
        .mem_rvalid(mem_rvalid),
        .mem_rdata (mem_rdata),
        .ready     (walker_ready),
        .resp      (walker_resp),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr)
    );

endmodule

// ==== tests/tb_pt_memory.sv ====
`timescale 1ns/1ps

module tb_pt_memory (
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_req,
    input  mmu_pkg::paddr_t mem_addr,
    output logic            mem_rvalid,
    output mmu_pkg::pte_t   mem_rdata,
    output int              read_count
);

    // root table at ppn 0x80, second-level table at ppn 0x90
    function automatic mmu_pkg::pte_t lookup_pte(input mmu_pkg::paddr_t addr);
        mmu_pkg::pte_t pte;
        // unmapped words read back invalid, v clear
        pte = {addr[33:12] ^ {addr[11:0], addr[33:24]}, 2'b00, 8'h00};
        case (addr)
            // vpn1 1 points to the second-level table
            34'h0_0008_0004: pte = {22'h00090, 2'b00, 8'h01};
            // vpn1 2 is a user read-only superpage
            34'h0_0008_0008: pte = {12'h345, 10'h000, 2'b00, 8'h13};
            // vpn1 3 has flags but v clear
            34'h0_0008_000c: pte = {22'h3f00f, 2'b00, 8'h1e};
            34'h0_0009_0040: pte = {22'h0a0c1, 2'b00, 8'h1b};
            34'h0_0009_0044: pte = {22'h0a0c2, 2'b00, 8'h1b};
            34'h0_0009_0048: pte = {22'h0a0c3, 2'b00, 8'h1b};
            // data page, no x
            34'h0_0009_0080: pte = {22'h0b001, 2'b00, 8'h17};
            default: ;
        endcase
        return pte;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_rvalid <= 1'b0;
            mem_rdata <= '0;
            read_count <= 0;
        end else begin
            mem_rvalid <= mem_req;
            if (mem_req) begin
                mem_rdata <= lookup_pte(mem_addr);
                read_count <= read_count + 1;
            end
        end
    end

endmodule

// ==== tests/tb_mmu.sv ====
`timescale 1ns/1ps

module tb_mmu;
    localparam int num_rows = 14;
    localparam int timeout_cycles = num_rows * 40;

    typedef struct packed {
        logic          flush;
        logic [1:0]    ireq;
        logic          dreq;
        logic          dstore;
        mmu_pkg::vpn_t ivpn0;
        mmu_pkg::vpn_t ivpn1;
        mmu_pkg::vpn_t dvpn;
        mmu_pkg::ppn_t iexp0;
        mmu_pkg::ppn_t iexp1;
        mmu_pkg::ppn_t dexp;
        logic [1:0]    iexc;
        logic          dexc;
        logic [3:0]    reads;
    } row_t;

    // pages of the model's page table and the ppns they map to
    localparam mmu_pkg::vpn_t no_vpn  = '0;
    localparam mmu_pkg::vpn_t vpn_a   = {10'h001, 10'h010};
    localparam mmu_pkg::vpn_t vpn_b   = {10'h001, 10'h011};
    localparam mmu_pkg::vpn_t vpn_c   = {10'h001, 10'h012};
    localparam mmu_pkg::vpn_t vpn_d   = {10'h001, 10'h020};
    localparam mmu_pkg::vpn_t vpn_sp  = {10'h002, 10'h155};
    localparam mmu_pkg::vpn_t vpn_sp2 = {10'h002, 10'h0aa};
    localparam mmu_pkg::vpn_t vpn_x   = {10'h003, 10'h000};
    localparam mmu_pkg::ppn_t no_ppn  = '0;
    localparam mmu_pkg::ppn_t ppn_a   = 22'h0a0c1;
    localparam mmu_pkg::ppn_t ppn_b   = 22'h0a0c2;
    localparam mmu_pkg::ppn_t ppn_c   = 22'h0a0c3;
    localparam mmu_pkg::ppn_t ppn_d   = 22'h0b001;
    // superpage keeps vpn0 of the vaddr
    localparam mmu_pkg::ppn_t ppn_sp  = {12'h345, 10'h155};
    localparam mmu_pkg::ppn_t ppn_sp2 = {12'h345, 10'h0aa};

    logic                  clk;
    logic                  rst;
    logic                  flush;
    mmu_pkg::ppn_t         satp_ppn;
    logic [1:0]            ireq;
    mmu_pkg::vaddr_t [1:0] ivaddr;
    logic                  iready;
    mmu_pkg::paddr_t [1:0] ipaddr;
    logic                  imiss;
    logic [1:0]            iexception;
    logic                  dreq;
    logic                  dstore;
    mmu_pkg::vaddr_t       dvaddr;
    logic                  dready;
    mmu_pkg::paddr_t       dpaddr;
    logic                  dmiss;
    logic                  dexception;
    logic                  mem_req;
    mmu_pkg::paddr_t       mem_addr;
    logic                  mem_rvalid;
    mmu_pkg::pte_t         mem_rdata;
    int                    read_count;

    row_t        rows [num_rows];
    logic [16:0] lfsr_state;
    int          errors;
    int          row_errors;
    int          rows_failed;
    int          cycles = 0;

    mmu_top #(.TLB_ENTRIES(8)) dut (
        .clk, .rst, .flush, .satp_ppn,
        .ireq, .ivaddr, .iready, .ipaddr, .imiss, .iexception,
        .dreq, .dstore, .dvaddr, .dready, .dpaddr, .dmiss, .dexception,
        .mem_req, .mem_addr, .mem_rvalid, .mem_rdata
    );

    tb_pt_memory u_memory (
        .clk, .rst, .mem_req, .mem_addr, .mem_rvalid, .mem_rdata, .read_count
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the table did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks

    task automatic check_paddr(input string name, input mmu_pkg::paddr_t got,
                               input mmu_pkg::paddr_t exp);
        if (got !== exp) begin
            errors++;
            row_errors++;
            $display("error t=%0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_exception(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            row_errors++;
            $display("error t=%0t %s: expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_reads(input int got, input int exp);
        if (got != exp) begin
            errors++;
            row_errors++;
            $display("error t=%0t walk reads: expected %0d, got %0d", $time, exp, got);
        end
    endtask

    // galois form of x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {1'b0, s[16:1]} ^ (s[0] ? 17'h12000 : 17'h00000);
    endfunction

    task automatic draw_offset(output logic [11:0] bits);
        for (int i = 0; i < 12; i++) begin
            bits[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table

    task automatic fill_table();
        // flush, ireq, dreq, dstore, vpns, expected ppns, iexc, dexc, reads
        rows[0]  = '{1'b0, 2'b01, 1'b0, 1'b0, vpn_a, no_vpn, no_vpn,
                     ppn_a, no_ppn, no_ppn, 2'b00, 1'b0, 4'd2};
        rows[1]  = '{1'b0, 2'b10, 1'b0, 1'b0, no_vpn, vpn_a, no_vpn,
                     no_ppn, ppn_a, no_ppn, 2'b00, 1'b0, 4'd0};
        rows[2]  = '{1'b0, 2'b11, 1'b0, 1'b0, vpn_b, vpn_c, no_vpn,
                     ppn_b, ppn_c, no_ppn, 2'b00, 1'b0, 4'd4};
        rows[3]  = '{1'b0, 2'b00, 1'b1, 1'b0, no_vpn, no_vpn, vpn_sp,
                     no_ppn, no_ppn, ppn_sp, 2'b00, 1'b0, 4'd1};
        // store to the read-only superpage
        rows[4]  = '{1'b0, 2'b00, 1'b1, 1'b1, no_vpn, no_vpn, vpn_sp2,
                     no_ppn, no_ppn, ppn_sp2, 2'b00, 1'b1, 4'd0};
        // fetch from the data page
        rows[5]  = '{1'b0, 2'b01, 1'b0, 1'b0, vpn_d, no_vpn, no_vpn,
                     ppn_d, no_ppn, no_ppn, 2'b01, 1'b0, 4'd2};
        rows[6]  = '{1'b0, 2'b00, 1'b1, 1'b0, no_vpn, no_vpn, vpn_x,
                     no_ppn, no_ppn, no_ppn, 2'b00, 1'b1, 4'd1};
        rows[7]  = '{1'b0, 2'b00, 1'b1, 1'b0, no_vpn, no_vpn, vpn_x,
                     no_ppn, no_ppn, no_ppn, 2'b00, 1'b1, 4'd1};
        rows[8]  = '{1'b0, 2'b01, 1'b0, 1'b0, vpn_a, no_vpn, no_vpn,
                     ppn_a, no_ppn, no_ppn, 2'b00, 1'b0, 4'd0};
        rows[9]  = '{1'b1, 2'b00, 1'b0, 1'b0, no_vpn, no_vpn, no_vpn,
                     no_ppn, no_ppn, no_ppn, 2'b00, 1'b0, 4'd0};
        rows[10] = '{1'b0, 2'b01, 1'b0, 1'b0, vpn_a, no_vpn, no_vpn,
                     ppn_a, no_ppn, no_ppn, 2'b00, 1'b0, 4'd2};
        // both translators miss in the same cycle
        rows[11] = '{1'b0, 2'b01, 1'b1, 1'b0, vpn_b, no_vpn, vpn_d,
                     ppn_b, no_ppn, ppn_d, 2'b00, 1'b0, 4'd4};
        rows[12] = '{1'b0, 2'b00, 1'b1, 1'b1, no_vpn, no_vpn, vpn_d,
                     no_ppn, no_ppn, ppn_d, 2'b00, 1'b0, 4'd0};
        rows[13] = '{1'b0, 2'b10, 1'b0, 1'b0, no_vpn, vpn_c, no_vpn,
                     no_ppn, ppn_c, no_ppn, 2'b00, 1'b0, 4'd2};
    endtask

    task automatic apply_row(input int n);
        row_t                  r;
        logic [11:0]           off0;
        logic [11:0]           off1;
        logic [11:0]           offd;
        mmu_pkg::paddr_t [1:0] iexp;
        int                    reads_before;
        r = rows[n];
        row_errors = 0;
        draw_offset(off0);
        draw_offset(off1);
        draw_offset(offd);
        iexp[0] = {r.iexp0, off0};
        iexp[1] = {r.iexp1, off1};
        @(posedge clk);
        #2;
        reads_before = read_count;
        flush = r.flush;
        ireq = r.ireq;
        ivaddr[0] = {r.ivpn0, off0};
        ivaddr[1] = {r.ivpn1, off1};
        dreq = r.dreq;
        dstore = r.dstore;
        dvaddr = {r.dvpn, offd};
        iready = 1'b0;
        dready = 1'b0;
        if (r.flush) begin
            @(posedge clk);
            #2;
            flush = 1'b0;
        end
        // a miss keeps imiss or dmiss high until its result is presented
        @(negedge clk);
        while (imiss || dmiss) begin
            @(negedge clk);
        end
        // ready is still low, so a finished miss keeps its result one more cycle
        for (int pass = 0; pass < 2; pass++) begin
            if (pass != 0) begin
                @(negedge clk);
            end
            for (int p = 0; p < 2; p++) begin
                if (r.ireq[p]) begin
                    check_exception($sformatf("iexception[%0d]", p), iexception[p],
                                    r.iexc[p]);
                    if (!r.iexc[p]) begin
                        check_paddr($sformatf("ipaddr[%0d]", p), ipaddr[p], iexp[p]);
                    end
                end
            end
            if (r.dreq) begin
                check_exception("dexception", dexception, r.dexc);
                if (!r.dexc) begin
                    check_paddr("dpaddr", dpaddr, {r.dexp, offd});
                end
            end
        end
        check_reads(read_count - reads_before, int'(r.reads));
        if (row_errors != 0) begin
            rows_failed++;
        end
        $display("row %0d %s, %0d walk reads", n, (row_errors == 0) ? "ok" : "failed",
                 read_count - reads_before);
        @(posedge clk);
        #2;
        ireq = 2'b00;
        dreq = 1'b0;
        dstore = 1'b0;
        iready = 1'b1;
        dready = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        satp_ppn = 22'h00080;
        ireq = 2'b00;
        ivaddr = '0;
        iready = 1'b1;
        dreq = 1'b0;
        dstore = 1'b0;
        dvaddr = '0;
        dready = 1'b1;
        lfsr_state = 17'd74998;
        errors = 0;
        row_errors = 0;
        rows_failed = 0;
        fill_table();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int n = 0; n < num_rows; n++) begin
            apply_row(n);
        end
        $display("%0d rows, %0d failed, %0d errors", num_rows, rows_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/mmu_pkg.sv
src/tlb_array.sv
src/itlb.sv
src/dtlb.sv
src/walk_arbiter.sv
src/page_walker.sv
src/mmu_top.sv
tests/tb_pt_memory.sv
tests/tb_mmu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mmu testbench with verilator
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary -sv --top-module tb_mmu -f project.f --Mdir obj_dir -o sim_mmu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mmu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$log"; then
    exit 1
fi
exit 0
